// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_dcache_top -f dcache_top.f

run: compile
	./obj_dir/Vtb_dcache_top | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dcache_assertions.sv
// dcache protocol assertions on the top-level core and memory ports
module dcache_assertions #(
    parameter int MEM_CREDITS = 2
) (
    input logic clk,
    input logic arst_n_i,
    input logic cpu_req_valid_i,
    input logic cpu_req_ready_o,
    input logic cpu_rsp_valid_o,
    input logic mem_req_valid_o,
    input logic mem_credit_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int   outstanding;
    logic in_flight;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            outstanding <= 0;
            in_flight   <= 1'b0;
        end else begin
            outstanding <= outstanding + int'(mem_req_valid_o) - int'(mem_credit_i);
            if (cpu_req_valid_i && cpu_req_ready_o) begin
                in_flight <= 1'b1;
            end else if (cpu_rsp_valid_o) begin
                in_flight <= 1'b0;
            end
        end
    end

    no_request_without_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_req_valid_o |-> outstanding < MEM_CREDITS)
        else $error("memory request with all credits outstanding");

    single_cycle_response: assert property (@(posedge clk) disable iff (!arst_n_i)
        cpu_rsp_valid_o |=> !cpu_rsp_valid_o)
        else $error("response valid held for two cycles");

    busy_while_in_flight: assert property (@(posedge clk) disable iff (!arst_n_i)
        (in_flight && !cpu_rsp_valid_o) |-> !cpu_req_ready_o)
        else $error("ready high while a request is in flight");

endmodule

bind dcache_top dcache_assertions #(.MEM_CREDITS(MEM_CREDITS)) u_assertions (
    .clk(clk), .arst_n_i(arst_n_i), .cpu_req_valid_i(cpu_req_valid_i),
    .cpu_req_ready_o(cpu_req_ready_o), .cpu_rsp_valid_o(cpu_rsp_valid_o),
    .mem_req_valid_o(mem_req_valid_o), .mem_credit_i(mem_credit_i)
);

// File: dcache_ctrl.sv
// dcache controller: miss handling FSM and memory credit counter
module dcache_ctrl #(
    parameter int MEM_CREDITS = 2,
    localparam int CRED_W = $clog2(MEM_CREDITS + 1)
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 cpu_req_valid_i,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    input  logic                 hit_i,
    input  dcache_pkg::way_t     hit_way_i,
    input  dcache_pkg::way_t     victim_way_i,
    input  logic                 victim_dirty_i,
    input  dcache_pkg::addr_t    victim_addr_i,
    input  dcache_pkg::word_t    victim_data_i,
    input  logic                 mem_credit_i,
    input  logic                 mem_rsp_valid_i,
    input  dcache_pkg::word_t    mem_rsp_data_i,
    output logic                 cpu_req_ready_o,
    output dcache_pkg::cpu_req_t req_o,
    output dcache_pkg::way_t     wr_way_o,
    output dcache_pkg::strb_t    data_we_o,
    output dcache_pkg::word_t    wdata_o,
    output logic                 fill_o,
    output logic                 mark_dirty_o,
    output logic                 touch_o,
    output logic                 respond_o,
    output dcache_pkg::way_t     resp_way_o,
    output logic                 mem_req_valid_o,
    output dcache_pkg::mem_req_t mem_req_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_CHECK,
        ST_WRITEBACK,
        ST_REFILL_REQ,
        ST_REFILL_WAIT
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic [CRED_W-1:0] credit_q;
    dcache_pkg::way_t  victim_q;
    logic              accept;
    logic              can_send;

    // stay busy until the response register has fired
    assign cpu_req_ready_o = (state_q == ST_IDLE) && !respond_o;
    assign accept          = cpu_req_valid_i && cpu_req_ready_o;
    assign can_send        = (credit_q != '0);

    always_comb begin
        state_d         = state_q;
        wr_way_o        = hit_way_i;
        data_we_o       = '0;
        wdata_o         = req_o.wdata;
        fill_o          = 1'b0;
        mark_dirty_o    = 1'b0;
        touch_o         = 1'b0;
        mem_req_valid_o = 1'b0;
        mem_req_o       = '0;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_READ;
                end
            end
            ST_READ: begin
                state_d = ST_CHECK;
            end
            ST_CHECK: begin
                if (hit_i) begin
                    touch_o = 1'b1;
                    if (req_o.write) begin
                        data_we_o    = req_o.strb;
                        mark_dirty_o = 1'b1;
                    end
                    state_d = ST_IDLE;
                end else if (victim_dirty_i) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL_REQ;
                end
            end
            ST_WRITEBACK: begin
                mem_req_o.write = 1'b1;
                mem_req_o.addr  = victim_addr_i;
                mem_req_o.data  = victim_data_i;
                if (can_send) begin
                    mem_req_valid_o = 1'b1;
                    state_d         = ST_REFILL_REQ;
                end
            end
            ST_REFILL_REQ: begin
                mem_req_o.addr = {req_o.addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W],
                                  {dcache_pkg::OFFSET_W{1'b0}}};
                if (can_send) begin
                    mem_req_valid_o = 1'b1;
                    state_d         = ST_REFILL_WAIT;
                end
            end
            ST_REFILL_WAIT: begin
                if (mem_rsp_valid_i) begin
                    wr_way_o  = victim_q;
                    data_we_o = '1;
                    wdata_o   = mem_rsp_data_i;
                    fill_o    = 1'b1;
                    // look up again, which now hits
                    state_d   = ST_READ;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            credit_q   <= CRED_W'(MEM_CREDITS);
            respond_o  <= 1'b0;
            resp_way_o <= 1'b0;
            victim_q   <= 1'b0;
        end else begin
            state_q   <= state_d;
            // send and return in one cycle cancel out
            credit_q  <= credit_q - CRED_W'(mem_req_valid_o) + CRED_W'(mem_credit_i);
            respond_o <= (state_q == ST_CHECK) && hit_i;
            if (state_q == ST_CHECK) begin
                resp_way_o <= hit_way_i;
                victim_q   <= victim_way_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_o <= cpu_req_i;
        end
    end

endmodule

// File: dcache_lookup.sv
// dcache lookup: splits the address, compares tags, picks hit and victim ways
module dcache_lookup #(
    parameter int SET_W = 6,
    localparam int TAG_W = dcache_pkg::ADDR_W - SET_W - dcache_pkg::OFFSET_W
) (
    input  dcache_pkg::addr_t addr_i,
    input  logic [TAG_W-1:0]  tag_i [2],
    input  logic              valid_i [2],
    input  logic              dirty_i [2],
    input  dcache_pkg::way_t  lru_way_i,
    output logic [SET_W-1:0]  index_o,
    output logic [TAG_W-1:0]  tag_o,
    output logic              hit_o,
    output dcache_pkg::way_t  hit_way_o,
    output dcache_pkg::way_t  victim_way_o,
    output logic              victim_dirty_o,
    output dcache_pkg::addr_t victim_addr_o
);

    logic [1:0] match;

    assign index_o = addr_i[dcache_pkg::OFFSET_W +: SET_W];
    assign tag_o   = addr_i[dcache_pkg::ADDR_W-1 -: TAG_W];

    assign match[0] = valid_i[0] && (tag_i[0] == tag_o);
    assign match[1] = valid_i[1] && (tag_i[1] == tag_o);

    assign hit_o     = |match;
    assign hit_way_o = match[1];

    // empty ways are filled before anything gets evicted
    always_comb begin
        if (!valid_i[0]) begin
            victim_way_o = 1'b0;
        end else if (!valid_i[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_way_i;
        end
    end

    assign victim_dirty_o = valid_i[victim_way_o] && dirty_i[victim_way_o];
    assign victim_addr_o  = {tag_i[victim_way_o], index_o, {dcache_pkg::OFFSET_W{1'b0}}};

endmodule

// File: dcache_pkg.sv
// dcache shared widths, vector types and core/memory request structs
package dcache_pkg;

    parameter int ADDR_W   = 32;
    parameter int OFFSET_W = 3;
    parameter int WORD_W   = 64;
    parameter int STRB_W   = WORD_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    // one word is also one full cache line
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic              way_t;

    // core request, 105 bits
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } cpu_req_t;

    // memory request, 97 bits, addr is word aligned
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t data;
    } mem_req_t;

endpackage

// File: dcache_resp.sv
// dcache response register: returns read data or write completion to the core
module dcache_resp (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              respond_i,
    input  logic              write_i,
    input  dcache_pkg::way_t  resp_way_i,
    input  dcache_pkg::word_t data_i [2],
    output logic              cpu_rsp_valid_o,
    output dcache_pkg::word_t cpu_rsp_data_o
);

    dcache_pkg::word_t rsp_word;

    // writes complete with zero data
    assign rsp_word = write_i ? '0 : data_i[resp_way_i];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cpu_rsp_valid_o <= 1'b0;
        end else begin
            cpu_rsp_valid_o <= respond_i;
        end
    end

    always_ff @(posedge clk) begin
        if (respond_i) begin
            cpu_rsp_data_o <= rsp_word;
        end
    end

endmodule

// File: dcache_store.sv
// dcache store: tag, valid, dirty, lru and data arrays for two ways with synchronous read
module dcache_store #(
    parameter int SET_W = 6,
    localparam int TAG_W = dcache_pkg::ADDR_W - SET_W - dcache_pkg::OFFSET_W
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic [SET_W-1:0]  index_i,
    input  dcache_pkg::way_t  wr_way_i,
    input  dcache_pkg::strb_t data_we_i,
    input  dcache_pkg::word_t wdata_i,
    input  logic              fill_i,
    input  logic [TAG_W-1:0]  tag_i,
    input  logic              mark_dirty_i,
    input  logic              touch_i,
    input  dcache_pkg::way_t  touch_way_i,
    output logic [TAG_W-1:0]  tag_o [2],
    output logic              valid_o [2],
    output logic              dirty_o [2],
    output dcache_pkg::word_t data_o [2],
    output dcache_pkg::way_t  lru_way_o
);

    localparam int SETS = 1 << SET_W;

    logic [TAG_W-1:0]  tag_mem  [2][SETS];
    dcache_pkg::word_t data_mem [2][SETS];
    logic [SETS-1:0]   valid_q  [2];
    logic [SETS-1:0]   dirty_q  [2];
    // per set, the way that was used least recently
    logic [SETS-1:0]   lru_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q   <= '{default: '0};
            dirty_q   <= '{default: '0};
            lru_q     <= '0;
            valid_o   <= '{default: 1'b0};
            dirty_o   <= '{default: 1'b0};
            lru_way_o <= 1'b0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                valid_o[w] <= valid_q[w][index_i];
                dirty_o[w] <= dirty_q[w][index_i];
            end
            lru_way_o <= lru_q[index_i];
            // a refilled line starts clean
            if (fill_i) begin
                valid_q[wr_way_i][index_i] <= 1'b1;
                dirty_q[wr_way_i][index_i] <= 1'b0;
            end
            if (mark_dirty_i) begin
                dirty_q[wr_way_i][index_i] <= 1'b1;
            end
            if (touch_i) begin
                lru_q[index_i] <= ~touch_way_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[wr_way_i][index_i] <= tag_i;
        end
        for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
            if (data_we_i[b]) begin
                data_mem[wr_way_i][index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
        // read returns the old contents on a same-cycle write
        for (int w = 0; w < 2; w++) begin
            tag_o[w]  <= tag_mem[w][index_i];
            data_o[w] <= data_mem[w][index_i];
        end
    end

endmodule

// File: dcache_top.f
dcache_pkg.sv
dcache_store.sv
dcache_lookup.sv
dcache_ctrl.sv
dcache_resp.sv
dcache_top.sv
dcache_assertions.sv
tb_dcache_top.sv

// File: dcache_top.sv
// dcache top: two-way write-back data cache with credit based memory port
module dcache_top #(
    parameter int SET_W       = 6,
    parameter int MEM_CREDITS = 2,
    localparam int TAG_W = dcache_pkg::ADDR_W - SET_W - dcache_pkg::OFFSET_W
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 cpu_req_valid_i,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    output logic                 cpu_req_ready_o,
    output logic                 cpu_rsp_valid_o,
    output dcache_pkg::word_t    cpu_rsp_data_o,
    output logic                 mem_req_valid_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  logic                 mem_credit_i,
    input  logic                 mem_rsp_valid_i,
    input  dcache_pkg::word_t    mem_rsp_data_i
);

    logic [SET_W-1:0]     index;
    logic [TAG_W-1:0]     req_tag;
    logic [TAG_W-1:0]     tag_rd [2];
    logic                 valid_rd [2];
    logic                 dirty_rd [2];
    dcache_pkg::word_t    data_rd [2];
    dcache_pkg::way_t     lru_way;
    dcache_pkg::cpu_req_t req;
    logic                 hit;
    dcache_pkg::way_t     hit_way;
    dcache_pkg::way_t     victim_way;
    logic                 victim_dirty;
    dcache_pkg::addr_t    victim_addr;
    dcache_pkg::way_t     wr_way;
    dcache_pkg::strb_t    data_we;
    dcache_pkg::word_t    wdata;
    logic                 fill;
    logic                 mark_dirty;
    logic                 touch;
    logic                 respond;
    dcache_pkg::way_t     resp_way;

    dcache_store #(.SET_W(SET_W)) u_store (
        .clk(clk), .arst_n_i(arst_n_i), .index_i(index), .wr_way_i(wr_way),
        .data_we_i(data_we), .wdata_i(wdata), .fill_i(fill), .tag_i(req_tag),
        .mark_dirty_i(mark_dirty), .touch_i(touch), .touch_way_i(wr_way),
        .tag_o(tag_rd), .valid_o(valid_rd), .dirty_o(dirty_rd), .data_o(data_rd),
        .lru_way_o(lru_way)
    );

    dcache_lookup #(.SET_W(SET_W)) u_lookup (
        .addr_i(req.addr), .tag_i(tag_rd), .valid_i(valid_rd), .dirty_i(dirty_rd),
        .lru_way_i(lru_way), .index_o(index), .tag_o(req_tag), .hit_o(hit),
        .hit_way_o(hit_way), .victim_way_o(victim_way), .victim_dirty_o(victim_dirty),
        .victim_addr_o(victim_addr)
    );

    dcache_ctrl #(.MEM_CREDITS(MEM_CREDITS)) u_ctrl (
        .clk(clk), .arst_n_i(arst_n_i), .cpu_req_valid_i(cpu_req_valid_i),
        .cpu_req_i(cpu_req_i), .hit_i(hit), .hit_way_i(hit_way),
        .victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
        .victim_addr_i(victim_addr), .victim_data_i(data_rd[victim_way]),
        .mem_credit_i(mem_credit_i), .mem_rsp_valid_i(mem_rsp_valid_i),
        .mem_rsp_data_i(mem_rsp_data_i), .cpu_req_ready_o(cpu_req_ready_o), .req_o(req),
        .wr_way_o(wr_way), .data_we_o(data_we), .wdata_o(wdata), .fill_o(fill),
        .mark_dirty_o(mark_dirty), .touch_o(touch), .respond_o(respond),
        .resp_way_o(resp_way), .mem_req_valid_o(mem_req_valid_o), .mem_req_o(mem_req_o)
    );

    dcache_resp u_resp (
        .clk(clk), .arst_n_i(arst_n_i), .respond_i(respond), .write_i(req.write),
        .resp_way_i(resp_way), .data_i(data_rd), .cpu_rsp_valid_o(cpu_rsp_valid_o),
        .cpu_rsp_data_o(cpu_rsp_data_o)
    );

endmodule

// File: tb_dcache_top.sv
// dcache testbench: random core traffic against a reference model and a credit memory
module tb_dcache_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_CREDITS    = 2;
    localparam int NUM_REQS       = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 40;
    localparam int RSP_LIMIT      = 200;
    localparam int HOLD_AT        = 200;
    localparam int HOLD_LEN       = 50;

    logic                 clk;
    logic                 arst_n_i;
    logic                 cpu_req_valid_i;
    dcache_pkg::cpu_req_t cpu_req_i;
    logic                 cpu_req_ready_o;
    logic                 cpu_rsp_valid_o;
    dcache_pkg::word_t    cpu_rsp_data_o;
    logic                 mem_req_valid_o;
    dcache_pkg::mem_req_t mem_req_o;
    logic                 mem_credit_i = 1'b0;
    logic                 mem_rsp_valid_i = 1'b0;
    dcache_pkg::word_t    mem_rsp_data_i = '0;

    dcache_pkg::word_t ref_mem [dcache_pkg::addr_t];
    dcache_pkg::word_t mem_model [dcache_pkg::addr_t];
    integer            seed = 4728;
    int                cycle = 0;
    int                hold_until = 0;
    int                mem_req_count = 0;
    int                outstanding = 0;
    int                credit_due [$];
    logic              rd_pending = 1'b0;
    dcache_pkg::addr_t rd_addr = '0;
    int                rd_due = 0;
    dcache_pkg::addr_t cur_addr = '0;

    dcache_top u_dcache_top (
        .clk(clk), .arst_n_i(arst_n_i), .cpu_req_valid_i(cpu_req_valid_i),
        .cpu_req_i(cpu_req_i), .cpu_req_ready_o(cpu_req_ready_o),
        .cpu_rsp_valid_o(cpu_rsp_valid_o), .cpu_rsp_data_o(cpu_rsp_data_o),
        .mem_req_valid_o(mem_req_valid_o), .mem_req_o(mem_req_o),
        .mem_credit_i(mem_credit_i), .mem_rsp_valid_i(mem_rsp_valid_i),
        .mem_rsp_data_i(mem_rsp_data_i)
    );

    // untouched memory holds a pattern built from the whole address
    function automatic dcache_pkg::word_t fill_word(input dcache_pkg::addr_t a);
        return {a ^ 32'h5a5a_0000, ~a};
    endfunction

    function automatic dcache_pkg::addr_t align(input dcache_pkg::addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    function automatic dcache_pkg::word_t ref_read(input dcache_pkg::addr_t a);
        return ref_mem.exists(align(a)) ? ref_mem[align(a)] : fill_word(align(a));
    endfunction

    function automatic dcache_pkg::word_t mem_read(input dcache_pkg::addr_t a);
        return mem_model.exists(align(a)) ? mem_model[align(a)] : fill_word(align(a));
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input dcache_pkg::word_t exp,
                              input dcache_pkg::word_t act);
        if (exp !== act) begin
            stop_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_req(input string name, input dcache_pkg::mem_req_t exp,
                             input dcache_pkg::mem_req_t act);
        if (exp !== act) begin
            stop_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            stop_run("run did not finish within the cycle limit");
        end
    end

    // memory with credits, random credit and refill delays
    always @(posedge clk) begin : memory_model
        int                   r;
        int                   due;
        dcache_pkg::mem_req_t exp;
        mem_credit_i    <= 1'b0;
        mem_rsp_valid_i <= 1'b0;
        if (arst_n_i && mem_req_valid_o) begin
            mem_req_count++;
            if (outstanding >= MEM_CREDITS) begin
                stop_run("memory request sent with no credit left");
            end
            if (mem_req_o.write) begin
                // victim shares the set of the missing request
                if (mem_req_o.addr[31:9] == cur_addr[31:9]) begin
                    stop_run("writeback of the line that is being refilled");
                end
                exp.write = 1'b1;
                exp.addr  = {mem_req_o.addr[31:9], cur_addr[8:3], 3'b000};
                exp.data  = ref_read(mem_req_o.addr);
                check_req("writeback request", exp, mem_req_o);
                check_word("writeback data", ref_read(mem_req_o.addr), mem_req_o.data);
                mem_model[align(mem_req_o.addr)] = mem_req_o.data;
            end else begin
                exp.write = 1'b0;
                exp.addr  = align(cur_addr);
                exp.data  = '0;
                check_req("refill request", exp, mem_req_o);
                if (rd_pending) begin
                    stop_run("second refill request while one is outstanding");
                end
                r          = $random(seed);
                rd_pending = 1'b1;
                rd_addr    = mem_req_o.addr;
                rd_due     = cycle + 1 + (r & 32'h7fff_ffff) % 6;
            end
            r   = $random(seed);
            due = cycle + 1 + (r & 32'h7fff_ffff) % 6;
            if (credit_due.size() > 0 && due <= credit_due[$]) begin
                due = credit_due[$] + 1;
            end
            credit_due.push_back(due);
            outstanding++;
        end
        if (cycle >= hold_until && credit_due.size() > 0 && credit_due[0] <= cycle) begin
            mem_credit_i <= 1'b1;
            void'(credit_due.pop_front());
            outstanding--;
        end
        if (rd_pending && cycle >= rd_due) begin
            mem_rsp_valid_i <= 1'b1;
            mem_rsp_data_i  <= mem_read(rd_addr);
            rd_pending = 1'b0;
        end
    end

    initial begin : stimulus
        int                   r;
        int                   lat;
        int                   reqs_before;
        logic                 repeat_req;
        dcache_pkg::addr_t    addr;
        dcache_pkg::addr_t    prev_addr;
        dcache_pkg::word_t    exp;
        dcache_pkg::word_t    merged;
        dcache_pkg::cpu_req_t req;
        arst_n_i        = 1'b0;
        cpu_req_valid_i = 1'b0;
        cpu_req_i       = '0;
        prev_addr       = '0;
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);
        if (!cpu_req_ready_o || cpu_rsp_valid_o || mem_req_valid_o) begin
            stop_run("port state after reset is not idle with ready high");
        end
        for (int i = 0; i < NUM_REQS; i++) begin
            r          = $random(seed);
            repeat_req = (i > 0) && (r[1:0] == 2'b00);
            if (repeat_req) begin
                addr = prev_addr;
            end else begin
                r    = $random(seed) & 32'h7fff_ffff;
                // three tags over four sets
                addr = dcache_pkg::addr_t'(((r % 3) + 1) * 512 + ((r >> 8) & 3) * 8
                                           + ((r >> 12) & 7));
            end
            r         = $random(seed);
            req.write = r[8];
            req.addr  = addr;
            req.wdata = {$random(seed), $random(seed)};
            req.strb  = r[7:0];
            if (i == HOLD_AT) begin
                hold_until <= cycle + HOLD_LEN;
            end
            cur_addr = addr;
            if (req.write) begin
                merged = ref_read(addr);
                for (int b = 0; b < 8; b++) begin
                    if (req.strb[b]) begin
                        merged[b*8 +: 8] = req.wdata[b*8 +: 8];
                    end
                end
                ref_mem[align(addr)] = merged;
                exp = '0;
            end else begin
                exp = ref_read(addr);
            end
            reqs_before = mem_req_count;
            cpu_req_valid_i <= 1'b1;
            cpu_req_i       <= req;
            do @(posedge clk); while (!cpu_req_ready_o);
            cpu_req_valid_i <= 1'b0;
            lat = 0;
            do begin
                @(posedge clk);
                lat++;
                if (lat > RSP_LIMIT) begin
                    stop_run("no response from the cache for an accepted request");
                end
            end while (!cpu_rsp_valid_o);
            check_word(req.write ? "write completion" : "read data", exp, cpu_rsp_data_o);
            // response was sampled one edge after it rose
            if (repeat_req && lat - 1 != 3) begin
                stop_run($sformatf("Fail hit latency expected 3 actual %0d", lat - 1));
            end
            if (repeat_req && mem_req_count != reqs_before) begin
                stop_run("a resident repeat request produced a memory request");
            end
            prev_addr = addr;
        end
        if (!rd_pending) begin
            $display("TESTS PASSED");
        end else begin
            $display("a refill read is still outstanding at the end of the run");
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
